// File: hdl/axi_pkg.sv
package axi_pkg;

   // Fixed bus geometry of the decoupler
   localparam int AXI_ID_W   = 4;
   localparam int AXI_ADDR_W = 32;
   localparam int AXI_DATA_W = 32;

   // Byte lanes per data word
   localparam int AXI_STRB_W = AXI_DATA_W / 8;

   // Transaction ID, shared by AW, B, AR and R
   typedef logic [AXI_ID_W-1:0]   axi_id_t;
   typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
   typedef logic [AXI_DATA_W-1:0] axi_data_t;

   // One strobe bit per byte lane
   typedef logic [AXI_STRB_W-1:0] axi_strb_t;

   // Beats in burst minus one
   typedef logic [7:0]            axi_len_t;

   // Log2 of bytes per beat
   typedef logic [2:0]            axi_size_t;

   // FIXED, INCR or WRAP
   typedef logic [1:0]            axi_burst_t;

   // OKAY, EXOKAY, SLVERR, DECERR
   typedef logic [1:0]            axi_resp_t;

endpackage

// File: hdl/decouple_pkg.sv
package decouple_pkg;

   // Outstanding request limits, backpressure starts here
   localparam int OUTST_WREQ = 8;
   localparam int OUTST_RREQ = 8;

   // Longest AXI4 INCR burst
   localparam int MAX_BEATS_PER_REQ = 256;

   // Worst case write beats still owed downstream
   localparam int OUTST_BEATS = OUTST_WREQ * MAX_BEATS_PER_REQ;

   // Counter types sized to hold the limit itself
   typedef logic [$clog2(OUTST_WREQ+1)-1:0]  req_cnt_t;
   typedef logic [$clog2(OUTST_BEATS+1)-1:0] beat_cnt_t;

   // Status vector bit positions
   localparam int STAT_AW  = 0;
   localparam int STAT_W   = 1;
   localparam int STAT_B   = 2;
   localparam int STAT_AR  = 3;
   localparam int STAT_R   = 4;
   localparam int STAT_NUM = 5;

   typedef logic [STAT_NUM-1:0] status_t;

endpackage

// File: hdl/axi_wr_decoupler.sv
`timescale 1ns/1ns

module axi_wr_decoupler import axi_pkg::*, decouple_pkg::*; (
   input  logic       aclk,
   input  logic       aresetn,
   input  logic       decouple,
   input  logic       decouple_force,
   // Upstream write channels
   input  axi_id_t    s_aw_id,
   input  axi_addr_t  s_aw_addr,
   input  axi_len_t   s_aw_len,
   input  axi_size_t  s_aw_size,
   input  axi_burst_t s_aw_burst,
   input  logic       s_aw_valid,
   output logic       s_aw_ready,
   input  axi_data_t  s_w_data,
   input  axi_strb_t  s_w_strb,
   input  logic       s_w_last,
   input  logic       s_w_valid,
   output logic       s_w_ready,
   output axi_id_t    s_b_id,
   output axi_resp_t  s_b_resp,
   output logic       s_b_valid,
   input  logic       s_b_ready,
   // Downstream write channels
   output axi_id_t    m_aw_id,
   output axi_addr_t  m_aw_addr,
   output axi_len_t   m_aw_len,
   output axi_size_t  m_aw_size,
   output axi_burst_t m_aw_burst,
   output logic       m_aw_valid,
   input  logic       m_aw_ready,
   output axi_data_t  m_w_data,
   output axi_strb_t  m_w_strb,
   output logic       m_w_last,
   output logic       m_w_valid,
   input  logic       m_w_ready,
   input  axi_id_t    m_b_id,
   input  axi_resp_t  m_b_resp,
   input  logic       m_b_valid,
   output logic       m_b_ready,
   // Status towards top and read side
   output logic       aw_decoupled,
   output logic       w_decoupled,
   output logic       b_decoupled,
   output logic       wr_idle
);

   logic      any;
   logic      aw_sticky;
   logic      aw_block;
   logic      w_block;
   logic      b_block;
   logic      aw_hs;
   logic      w_hs;
   logic      b_hs;
   req_cnt_t  resp_cnt;
   beat_cnt_t beat_cnt;
   beat_cnt_t beat_add;

   assign any = decouple | decouple_force;

   // AW held off once decoupling, unless a request is already presented
   assign aw_block = (any && !aw_sticky) || (resp_cnt == req_cnt_t'(OUTST_WREQ));
   // W and B close only when nothing is owed on them
   assign w_block  = any && (beat_cnt == '0);
   assign b_block  = any && (resp_cnt == '0);

   // Payload passes straight through
   assign m_aw_id    = s_aw_id;
   assign m_aw_addr  = s_aw_addr;
   assign m_aw_len   = s_aw_len;
   assign m_aw_size  = s_aw_size;
   assign m_aw_burst = s_aw_burst;
   assign m_w_data   = s_w_data;
   assign m_w_last   = s_w_last;
   assign s_b_id     = m_b_id;
   assign s_b_resp   = m_b_resp;

   // Sticky bit keeps downstream valid up after upstream drops it
   assign m_aw_valid = aw_block ? 1'b0 : (s_aw_valid | aw_sticky);
   assign s_aw_ready = aw_block ? 1'b0 : m_aw_ready;

   // Forced mode drains owed beats with empty strobes
   assign m_w_valid = w_block ? 1'b0 : (decouple_force | s_w_valid);
   assign m_w_strb  = (!w_block && decouple_force) ? '0 : s_w_strb;
   assign s_w_ready = w_block ? 1'b0 : m_w_ready;

   // Forced mode swallows every pending response
   assign s_b_valid = b_block ? 1'b0 : m_b_valid;
   assign m_b_ready = b_block ? 1'b0 : (decouple_force | s_b_ready);

   assign aw_hs = m_aw_valid & m_aw_ready;
   assign w_hs  = m_w_valid & m_w_ready;
   assign b_hs  = m_b_valid & m_b_ready;

   // Beats added by one accepted AW
   assign beat_add = aw_hs ? beat_cnt_t'(m_aw_len) + beat_cnt_t'(1) : '0;

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         aw_sticky <= 1'b0;
      end else if (s_aw_valid && !m_aw_ready && !any) begin
         aw_sticky <= 1'b1;
      end else if (m_aw_ready) begin
         aw_sticky <= 1'b0;
      end
   end

   // Responses owed, one per accepted AW
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         resp_cnt <= '0;
      end else if (aw_hs && !b_hs) begin
         resp_cnt <= resp_cnt + req_cnt_t'(1);
      end else if (b_hs && !aw_hs) begin
         resp_cnt <= resp_cnt - req_cnt_t'(1);
      end
   end

   // Beats owed, AW and W may land together
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         beat_cnt <= '0;
      end else begin
         beat_cnt <= beat_cnt + beat_add - beat_cnt_t'(w_hs);
      end
   end

   assign aw_decoupled = any && !aw_sticky;
   assign w_decoupled  = w_block && aw_decoupled;
   assign b_decoupled  = b_block && aw_decoupled;
   assign wr_idle      = (beat_cnt == '0) && (resp_cnt == '0) && !aw_sticky;

   // B only for a write that was issued
   a_resp_no_underflow: assert property (@(posedge aclk) disable iff (!aresetn)
      (resp_cnt == '0) |-> !(b_hs && !aw_hs))
      else $error("write response without outstanding AW");

   a_beat_bound: assert property (@(posedge aclk) disable iff (!aresetn)
      beat_cnt <= beat_cnt_t'(OUTST_BEATS))
      else $error("outstanding write beats above limit");

   a_aw_limit: assert property (@(posedge aclk) disable iff (!aresetn)
      (resp_cnt == req_cnt_t'(OUTST_WREQ)) |-> !aw_hs)
      else $error("AW accepted at outstanding limit");

endmodule

// File: hdl/axi_rd_decoupler.sv
`timescale 1ns/1ns

module axi_rd_decoupler import axi_pkg::*, decouple_pkg::*; (
   input  logic       aclk,
   input  logic       aresetn,
   input  logic       decouple,
   input  logic       decouple_force,
   // Upstream read channels
   input  axi_id_t    s_ar_id,
   input  axi_addr_t  s_ar_addr,
   input  axi_len_t   s_ar_len,
   input  axi_size_t  s_ar_size,
   input  axi_burst_t s_ar_burst,
   input  logic       s_ar_valid,
   output logic       s_ar_ready,
   output axi_id_t    s_r_id,
   output axi_data_t  s_r_data,
   output axi_resp_t  s_r_resp,
   output logic       s_r_last,
   output logic       s_r_valid,
   input  logic       s_r_ready,
   // Downstream read channels
   output axi_id_t    m_ar_id,
   output axi_addr_t  m_ar_addr,
   output axi_len_t   m_ar_len,
   output axi_size_t  m_ar_size,
   output axi_burst_t m_ar_burst,
   output logic       m_ar_valid,
   input  logic       m_ar_ready,
   input  axi_id_t    m_r_id,
   input  axi_data_t  m_r_data,
   input  axi_resp_t  m_r_resp,
   input  logic       m_r_last,
   input  logic       m_r_valid,
   output logic       m_r_ready,
   // Write side idle, for the done flag
   input  logic       wr_idle,
   output logic       ar_decoupled,
   output logic       r_decoupled,
   output logic       decouple_done
);

   logic     any;
   logic     ar_sticky;
   logic     ar_block;
   logic     r_block;
   logic     ar_hs;
   logic     r_last_hs;
   req_cnt_t burst_cnt;

   assign any = decouple | decouple_force;

   // Same gating as AW, limited by open bursts
   assign ar_block = (any && !ar_sticky) || (burst_cnt == req_cnt_t'(OUTST_RREQ));
   assign r_block  = any && (burst_cnt == '0);

   assign m_ar_id    = s_ar_id;
   assign m_ar_addr  = s_ar_addr;
   assign m_ar_len   = s_ar_len;
   assign m_ar_size  = s_ar_size;
   assign m_ar_burst = s_ar_burst;
   assign s_r_id     = m_r_id;
   assign s_r_data   = m_r_data;
   assign s_r_resp   = m_r_resp;
   assign s_r_last   = m_r_last;

   assign m_ar_valid = ar_block ? 1'b0 : (s_ar_valid | ar_sticky);
   assign s_ar_ready = ar_block ? 1'b0 : m_ar_ready;

   // Forced mode accepts read data regardless of upstream
   assign s_r_valid = r_block ? 1'b0 : m_r_valid;
   assign m_r_ready = r_block ? 1'b0 : (decouple_force | s_r_ready);

   assign ar_hs     = m_ar_valid & m_ar_ready;
   // A burst closes on its last beat only
   assign r_last_hs = m_r_valid & m_r_ready & m_r_last;

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         ar_sticky <= 1'b0;
      end else if (s_ar_valid && !m_ar_ready && !any) begin
         ar_sticky <= 1'b1;
      end else if (m_ar_ready) begin
         ar_sticky <= 1'b0;
      end
   end

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         burst_cnt <= '0;
      end else if (ar_hs && !r_last_hs) begin
         burst_cnt <= burst_cnt + req_cnt_t'(1);
      end else if (r_last_hs && !ar_hs) begin
         burst_cnt <= burst_cnt - req_cnt_t'(1);
      end
   end

   assign ar_decoupled = any && !ar_sticky;
   assign r_decoupled  = r_block;

   // Passive request only, force alone never reports done
   assign decouple_done = decouple && wr_idle && (burst_cnt == '0) && !ar_sticky;

   a_r_last_owed: assert property (@(posedge aclk) disable iff (!aresetn)
      (burst_cnt == '0) |-> !r_last_hs)
      else $error("R last accepted with no open read burst");

   // Presented AR must stay up until taken
   a_ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
      (m_ar_valid && !m_ar_ready) |=> m_ar_valid)
      else $error("downstream AR valid dropped before ready");

endmodule

// File: hdl/axi_master_decoupler.sv
`timescale 1ns/1ns

module axi_master_decoupler import axi_pkg::*, decouple_pkg::*; (
   input  logic       aclk,
   input  logic       aresetn,
   // Upstream, facing the issuing master
   input  axi_id_t    s_aw_id,
   input  axi_addr_t  s_aw_addr,
   input  axi_len_t   s_aw_len,
   input  axi_size_t  s_aw_size,
   input  axi_burst_t s_aw_burst,
   input  logic       s_aw_valid,
   output logic       s_aw_ready,
   input  axi_data_t  s_w_data,
   input  axi_strb_t  s_w_strb,
   input  logic       s_w_last,
   input  logic       s_w_valid,
   output logic       s_w_ready,
   output axi_id_t    s_b_id,
   output axi_resp_t  s_b_resp,
   output logic       s_b_valid,
   input  logic       s_b_ready,
   input  axi_id_t    s_ar_id,
   input  axi_addr_t  s_ar_addr,
   input  axi_len_t   s_ar_len,
   input  axi_size_t  s_ar_size,
   input  axi_burst_t s_ar_burst,
   input  logic       s_ar_valid,
   output logic       s_ar_ready,
   output axi_id_t    s_r_id,
   output axi_data_t  s_r_data,
   output axi_resp_t  s_r_resp,
   output logic       s_r_last,
   output logic       s_r_valid,
   input  logic       s_r_ready,
   // Downstream, facing memory
   output axi_id_t    m_aw_id,
   output axi_addr_t  m_aw_addr,
   output axi_len_t   m_aw_len,
   output axi_size_t  m_aw_size,
   output axi_burst_t m_aw_burst,
   output logic       m_aw_valid,
   input  logic       m_aw_ready,
   output axi_data_t  m_w_data,
   output axi_strb_t  m_w_strb,
   output logic       m_w_last,
   output logic       m_w_valid,
   input  logic       m_w_ready,
   input  axi_id_t    m_b_id,
   input  axi_resp_t  m_b_resp,
   input  logic       m_b_valid,
   output logic       m_b_ready,
   output axi_id_t    m_ar_id,
   output axi_addr_t  m_ar_addr,
   output axi_len_t   m_ar_len,
   output axi_size_t  m_ar_size,
   output axi_burst_t m_ar_burst,
   output logic       m_ar_valid,
   input  logic       m_ar_ready,
   input  axi_id_t    m_r_id,
   input  axi_data_t  m_r_data,
   input  axi_resp_t  m_r_resp,
   input  logic       m_r_last,
   input  logic       m_r_valid,
   output logic       m_r_ready,
   // Decouple control
   input  logic       decouple,
   input  logic       decouple_force,
   output logic       decouple_done,
   output status_t    status
);

   // Per-channel status from the two halves
   logic aw_decoupled;
   logic w_decoupled;
   logic b_decoupled;
   logic ar_decoupled;
   logic r_decoupled;

   // Write side fully drained
   logic wr_idle;

   // Port names match the channel ports one to one
   axi_wr_decoupler i_wr_decoupler (.*);

   axi_rd_decoupler i_rd_decoupler (.*);

   assign status[STAT_AW] = aw_decoupled;
   assign status[STAT_W]  = w_decoupled;
   assign status[STAT_B]  = b_decoupled;
   assign status[STAT_AR] = ar_decoupled;
   assign status[STAT_R]  = r_decoupled;

endmodule

// File: tb/tb_axi_master_decoupler.sv
`timescale 1ns/1ns

module tb_axi_master_decoupler import axi_pkg::*, decouple_pkg::*; ();

   // Cycles any single wait may take
   localparam int TIMEOUT_CYCLES = 64;

   logic       aclk;
   logic       aresetn;
   // Upstream side, driven by the tb as master
   axi_id_t    s_aw_id;
   axi_addr_t  s_aw_addr;
   axi_len_t   s_aw_len;
   axi_size_t  s_aw_size;
   axi_burst_t s_aw_burst;
   logic       s_aw_valid;
   logic       s_aw_ready;
   axi_data_t  s_w_data;
   axi_strb_t  s_w_strb;
   logic       s_w_last;
   logic       s_w_valid;
   logic       s_w_ready;
   axi_id_t    s_b_id;
   axi_resp_t  s_b_resp;
   logic       s_b_valid;
   logic       s_b_ready;
   axi_id_t    s_ar_id;
   axi_addr_t  s_ar_addr;
   axi_len_t   s_ar_len;
   axi_size_t  s_ar_size;
   axi_burst_t s_ar_burst;
   logic       s_ar_valid;
   logic       s_ar_ready;
   axi_id_t    s_r_id;
   axi_data_t  s_r_data;
   axi_resp_t  s_r_resp;
   logic       s_r_last;
   logic       s_r_valid;
   logic       s_r_ready;
   // Downstream side, driven by the tb as memory
   axi_id_t    m_aw_id;
   axi_addr_t  m_aw_addr;
   axi_len_t   m_aw_len;
   axi_size_t  m_aw_size;
   axi_burst_t m_aw_burst;
   logic       m_aw_valid;
   logic       m_aw_ready;
   axi_data_t  m_w_data;
   axi_strb_t  m_w_strb;
   logic       m_w_last;
   logic       m_w_valid;
   logic       m_w_ready;
   axi_id_t    m_b_id;
   axi_resp_t  m_b_resp;
   logic       m_b_valid;
   logic       m_b_ready;
   axi_id_t    m_ar_id;
   axi_addr_t  m_ar_addr;
   axi_len_t   m_ar_len;
   axi_size_t  m_ar_size;
   axi_burst_t m_ar_burst;
   logic       m_ar_valid;
   logic       m_ar_ready;
   axi_id_t    m_r_id;
   axi_data_t  m_r_data;
   axi_resp_t  m_r_resp;
   logic       m_r_last;
   logic       m_r_valid;
   logic       m_r_ready;
   logic       decouple;
   logic       decouple_force;
   logic       decouple_done;
   status_t    status;

   int mismatch_cnt;
   int failure_cnt;
   int seed_val;

   always #50 aclk = ~aclk;

   axi_master_decoupler i_dut (.*);

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("MISMATCH %s expected %h got %h", name, exp, act);
         mismatch_cnt++;
      end
   endtask

   task automatic check_data(input string name, input axi_data_t exp, input axi_data_t act);
      if (act !== exp) begin
         $display("MISMATCH %s expected %h got %h", name, exp, act);
         mismatch_cnt++;
      end
   endtask

   task automatic check_addr(input string name, input axi_addr_t exp, input axi_addr_t act);
      if (act !== exp) begin
         $display("MISMATCH %s expected %h got %h", name, exp, act);
         mismatch_cnt++;
      end
   endtask

   task automatic check_id(input string name, input axi_id_t exp, input axi_id_t act);
      if (act !== exp) begin
         $display("MISMATCH %s expected %h got %h", name, exp, act);
         mismatch_cnt++;
      end
   endtask

   task automatic check_len(input string name, input axi_len_t exp, input axi_len_t act);
      if (act !== exp) begin
         $display("MISMATCH %s expected %h got %h", name, exp, act);
         mismatch_cnt++;
      end
   endtask

   task automatic check_size(input string name, input axi_size_t exp, input axi_size_t act);
      if (act !== exp) begin
         $display("MISMATCH %s expected %h got %h", name, exp, act);
         mismatch_cnt++;
      end
   endtask

   task automatic check_burst(input string name, input axi_burst_t exp, input axi_burst_t act);
      if (act !== exp) begin
         $display("MISMATCH %s expected %h got %h", name, exp, act);
         mismatch_cnt++;
      end
   endtask

   task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
      if (act !== exp) begin
         $display("MISMATCH %s expected %h got %h", name, exp, act);
         mismatch_cnt++;
      end
   endtask

   task automatic check_strb(input string name, input axi_strb_t exp, input axi_strb_t act);
      if (act !== exp) begin
         $display("MISMATCH %s expected %h got %h", name, exp, act);
         mismatch_cnt++;
      end
   endtask

   task automatic check_status(input string name, input status_t exp, input status_t act);
      if (act !== exp) begin
         $display("MISMATCH %s expected %h got %h", name, exp, act);
         mismatch_cnt++;
      end
   endtask

   // Expected status vector from per-channel flags
   function automatic status_t make_status(
      input logic aw,
      input logic w,
      input logic b,
      input logic ar,
      input logic r
   );
      status_t st;
      st          = '0;
      st[STAT_AW] = aw;
      st[STAT_W]  = w;
      st[STAT_B]  = b;
      st[STAT_AR] = ar;
      st[STAT_R]  = r;
      return st;
   endfunction

   // Readies the driver tasks wait on
   function automatic logic ready_value(input string name);
      if (name == "s_aw_ready") return s_aw_ready;
      if (name == "s_w_ready") return s_w_ready;
      if (name == "s_ar_ready") return s_ar_ready;
      if (name == "m_b_ready") return m_b_ready;
      if (name == "m_r_ready") return m_r_ready;
      return 1'b0;
   endfunction

   task automatic idle_inputs();
      {s_aw_id, s_aw_addr, s_aw_len, s_aw_size, s_aw_burst, s_aw_valid} = '0;
      {s_w_data, s_w_strb, s_w_last, s_w_valid, s_b_ready} = '0;
      {s_ar_id, s_ar_addr, s_ar_len, s_ar_size, s_ar_burst, s_ar_valid} = '0;
      s_r_ready = 1'b0;
      {m_aw_ready, m_w_ready, m_ar_ready} = '0;
      {m_b_id, m_b_resp, m_b_valid} = '0;
      {m_r_id, m_r_data, m_r_resp, m_r_last, m_r_valid} = '0;
      decouple       = 1'b0;
      decouple_force = 1'b0;
   endtask

   task automatic apply_reset();
      @(negedge aclk);
      idle_inputs();
      aresetn = 1'b0;
      repeat (4) @(posedge aclk);
      @(negedge aclk);
      aresetn = 1'b1;
   endtask

   // Sample point sits between the falling and the rising edge
   task automatic wait_high(input string name);
      int   cycles;
      logic seen;
      seen   = 1'b0;
      cycles = 0;
      #10;
      while (!seen && cycles < TIMEOUT_CYCLES) begin
         if (ready_value(name)) begin
            seen = 1'b1;
         end else begin
            @(negedge aclk);
            #10;
            cycles++;
         end
      end
      if (!seen) begin
         $display("Timeout waiting for %s to go high", name);
         failure_cnt++;
      end
   endtask

   // Master drives one AW, dropped after the handshake edge
   task automatic send_aw(input axi_id_t id, input axi_addr_t addr, input axi_len_t len);
      s_aw_id    = id;
      s_aw_addr  = addr;
      s_aw_len   = len;
      s_aw_size  = 3'd2;
      s_aw_burst = 2'd1;
      s_aw_valid = 1'b1;
      wait_high("s_aw_ready");
      check_bit("m_aw_valid", 1'b1, m_aw_valid);
      check_id("m_aw_id", id, m_aw_id);
      check_addr("m_aw_addr", addr, m_aw_addr);
      check_len("m_aw_len", len, m_aw_len);
      check_size("m_aw_size", 3'd2, m_aw_size);
      check_burst("m_aw_burst", 2'd1, m_aw_burst);
      @(negedge aclk);
      s_aw_valid = 1'b0;
   endtask

   task automatic send_w(input axi_data_t data, input axi_strb_t strb, input logic last);
      s_w_data  = data;
      s_w_strb  = strb;
      s_w_last  = last;
      s_w_valid = 1'b1;
      wait_high("s_w_ready");
      check_data("m_w_data", data, m_w_data);
      check_strb("m_w_strb", strb, m_w_strb);
      check_bit("m_w_last", last, m_w_last);
      @(negedge aclk);
      s_w_valid = 1'b0;
   endtask

   task automatic send_ar(input axi_id_t id, input axi_addr_t addr, input axi_len_t len);
      s_ar_id    = id;
      s_ar_addr  = addr;
      s_ar_len   = len;
      s_ar_size  = 3'd2;
      s_ar_burst = 2'd1;
      s_ar_valid = 1'b1;
      wait_high("s_ar_ready");
      check_bit("m_ar_valid", 1'b1, m_ar_valid);
      check_id("m_ar_id", id, m_ar_id);
      check_addr("m_ar_addr", addr, m_ar_addr);
      check_len("m_ar_len", len, m_ar_len);
      check_size("m_ar_size", 3'd2, m_ar_size);
      check_burst("m_ar_burst", 2'd1, m_ar_burst);
      @(negedge aclk);
      s_ar_valid = 1'b0;
   endtask

   // Memory model returns one write response
   task automatic return_b(input axi_id_t id, input axi_resp_t resp);
      m_b_id    = id;
      m_b_resp  = resp;
      m_b_valid = 1'b1;
      wait_high("m_b_ready");
      check_bit("s_b_valid", 1'b1, s_b_valid);
      check_id("s_b_id", id, s_b_id);
      check_resp("s_b_resp", resp, s_b_resp);
      @(negedge aclk);
      m_b_valid = 1'b0;
   endtask

   // Memory model returns one read beat
   task automatic return_r(
      input axi_id_t   id,
      input axi_data_t data,
      input axi_resp_t resp,
      input logic      last
   );
      m_r_id    = id;
      m_r_data  = data;
      m_r_resp  = resp;
      m_r_last  = last;
      m_r_valid = 1'b1;
      wait_high("m_r_ready");
      check_bit("s_r_valid", 1'b1, s_r_valid);
      check_id("s_r_id", id, s_r_id);
      check_data("s_r_data", data, s_r_data);
      check_resp("s_r_resp", resp, s_r_resp);
      check_bit("s_r_last", last, s_r_last);
      @(negedge aclk);
      m_r_valid = 1'b0;
   endtask

   task automatic test_pass_through();
      axi_data_t d0;
      axi_data_t d1;
      apply_reset();
      d0 = $urandom();
      d1 = $urandom();
      {m_aw_ready, m_w_ready, m_ar_ready, s_b_ready, s_r_ready} = '1;
      send_aw(4'h3, $urandom(), 8'd1);
      send_w(d0, 4'hF, 1'b0);
      send_w(d1, 4'h6, 1'b1);
      return_b(4'h3, 2'b10);
      send_ar(4'h5, $urandom(), 8'd0);
      return_r(4'h5, d0 ^ d1, 2'b01, 1'b1);
      #10;
      check_status("status", '0, status);
      check_bit("decouple_done", 1'b0, decouple_done);
   endtask

   task automatic test_idle_decouple();
      apply_reset();
      decouple   = 1'b1;
      s_aw_addr  = $urandom();
      {s_aw_valid, s_w_valid, s_ar_valid, m_b_valid, m_r_valid} = '1;
      {m_aw_ready, m_w_ready, m_ar_ready, s_b_ready, s_r_ready} = '1;
      #10;
      check_status("status", 5'h1F, status);
      check_bit("decouple_done", 1'b1, decouple_done);
      check_bit("m_aw_valid", 1'b0, m_aw_valid);
      check_bit("m_w_valid", 1'b0, m_w_valid);
      check_bit("m_ar_valid", 1'b0, m_ar_valid);
      check_bit("m_b_ready", 1'b0, m_b_ready);
      check_bit("m_r_ready", 1'b0, m_r_ready);
      check_bit("s_aw_ready", 1'b0, s_aw_ready);
      check_bit("s_w_ready", 1'b0, s_w_ready);
      check_bit("s_ar_ready", 1'b0, s_ar_ready);
      check_bit("s_b_valid", 1'b0, s_b_valid);
      check_bit("s_r_valid", 1'b0, s_r_valid);
      // Held AW must still not leak a cycle later
      @(negedge aclk);
      #10;
      check_bit("m_aw_valid", 1'b0, m_aw_valid);
   endtask

   task automatic test_passive_write();
      apply_reset();
      {m_aw_ready, m_w_ready, s_b_ready} = '1;
      send_aw(4'h1, $urandom(), 8'd1);
      send_w($urandom(), 4'hF, 1'b0);
      decouple = 1'b1;
      #10;
      check_status("status", make_status(1, 0, 0, 1, 1), status);
      check_bit("decouple_done", 1'b0, decouple_done);
      @(negedge aclk);
      send_w($urandom(), 4'hF, 1'b1);
      // Last beat gone, W closes
      #10;
      check_status("status", make_status(1, 1, 0, 1, 1), status);
      check_bit("decouple_done", 1'b0, decouple_done);
      @(negedge aclk);
      return_b(4'h1, 2'b00);
      #10;
      check_status("status", 5'h1F, status);
      check_bit("decouple_done", 1'b1, decouple_done);
   endtask

   task automatic test_forced();
      int beats;
      int cycles;
      apply_reset();
      {m_aw_ready, m_ar_ready} = '1;
      send_aw(4'h2, $urandom(), 8'd3);
      send_ar(4'h4, $urandom(), 8'd0);
      // Upstream lanes all enabled, forced beats still go out empty
      s_w_strb       = 4'hF;
      decouple_force = 1'b1;
      #10;
      check_bit("m_w_valid", 1'b1, m_w_valid);
      check_strb("m_w_strb", '0, m_w_strb);
      check_bit("m_b_ready", 1'b1, m_b_ready);
      check_bit("m_r_ready", 1'b1, m_r_ready);
      check_status("status", make_status(1, 0, 0, 1, 0), status);
      check_bit("decouple_done", 1'b0, decouple_done);
      @(negedge aclk);
      m_w_ready = 1'b1;
      // Count zero-strobe beats memory takes
      beats  = 0;
      cycles = 0;
      #10;
      while (beats < 4 && cycles < TIMEOUT_CYCLES) begin
         if (m_w_valid && m_w_ready) begin
            check_strb("m_w_strb", '0, m_w_strb);
            beats++;
         end
         @(negedge aclk);
         #10;
         cycles++;
      end
      if (beats != 4) begin
         $display("Timeout waiting for forced write beats, got %0d of 4", beats);
         failure_cnt++;
      end
      check_bit("m_w_valid", 1'b0, m_w_valid);
      check_status("status", make_status(1, 1, 0, 1, 0), status);
      @(negedge aclk);
      m_w_ready = 1'b0;
      // Upstream readies stay low, force drains responses anyway
      return_b(4'h2, 2'b00);
      return_r(4'h4, $urandom(), 2'b00, 1'b1);
      #10;
      check_status("status", 5'h1F, status);
      check_bit("decouple_done", 1'b0, decouple_done);
      @(negedge aclk);
      decouple = 1'b1;
      #10;
      check_bit("decouple_done", 1'b1, decouple_done);
   endtask

   task automatic test_backpressure();
      apply_reset();
      {m_ar_ready, s_r_ready} = '1;
      for (int i = 0; i < OUTST_RREQ; i++) begin
         send_ar(axi_id_t'(i), $urandom(), 8'd0);
      end
      s_ar_addr  = $urandom();
      s_ar_valid = 1'b1;
      #10;
      check_bit("s_ar_ready", 1'b0, s_ar_ready);
      check_bit("m_ar_valid", 1'b0, m_ar_valid);
      @(negedge aclk);
      return_r(4'h0, $urandom(), 2'b00, 1'b1);
      #10;
      check_bit("s_ar_ready", 1'b1, s_ar_ready);
      check_bit("m_ar_valid", 1'b1, m_ar_valid);
      @(negedge aclk);
      s_ar_valid = 1'b0;

      // Same limit on the write side
      apply_reset();
      {m_aw_ready, s_b_ready} = '1;
      for (int i = 0; i < OUTST_WREQ; i++) begin
         send_aw(axi_id_t'(i), $urandom(), 8'd0);
      end
      s_aw_valid = 1'b1;
      #10;
      check_bit("s_aw_ready", 1'b0, s_aw_ready);
      check_bit("m_aw_valid", 1'b0, m_aw_valid);
      @(negedge aclk);
      return_b(4'h0, 2'b00);
      #10;
      check_bit("s_aw_ready", 1'b1, s_aw_ready);
      check_bit("m_aw_valid", 1'b1, m_aw_valid);
      @(negedge aclk);
      s_aw_valid = 1'b0;
   endtask

   task automatic test_sticky_ar();
      apply_reset();
      s_ar_addr  = $urandom();
      s_ar_valid = 1'b1;
      #10;
      check_bit("m_ar_valid", 1'b1, m_ar_valid);
      // Request presented, withdrawn as decouple rises
      @(negedge aclk);
      s_ar_valid = 1'b0;
      decouple   = 1'b1;
      #10;
      check_bit("m_ar_valid", 1'b1, m_ar_valid);
      check_status("status", make_status(1, 1, 1, 0, 1), status);
      check_bit("decouple_done", 1'b0, decouple_done);
      @(negedge aclk);
      #10;
      check_bit("m_ar_valid", 1'b1, m_ar_valid);
      check_status("status", make_status(1, 1, 1, 0, 1), status);
      @(negedge aclk);
      m_ar_ready = 1'b1;
      #10;
      check_bit("m_ar_valid", 1'b1, m_ar_valid);
      @(negedge aclk);
      m_ar_ready = 1'b0;
      // Burst now open, so R stays connected
      #10;
      check_bit("m_ar_valid", 1'b0, m_ar_valid);
      check_status("status", make_status(1, 1, 1, 1, 0), status);
      check_bit("decouple_done", 1'b0, decouple_done);
   endtask

   initial begin
      aclk         = 1'b0;
      aresetn      = 1'b0;
      mismatch_cnt = 0;
      failure_cnt  = 0;
      idle_inputs();
      seed_val = $urandom(32'hb2dacb03);
      test_pass_through();
      test_idle_decouple();
      test_passive_write();
      test_forced();
      test_backpressure();
      test_sticky_ar();
      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, failure_cnt);
      if (mismatch_cnt == 0 && failure_cnt == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: src.f
hdl/axi_pkg.sv
hdl/decouple_pkg.sv
hdl/axi_wr_decoupler.sv
hdl/axi_rd_decoupler.sv
hdl/axi_master_decoupler.sv
tb/tb_axi_master_decoupler.sv
